// File: dmni.f
hdl/dmni_pkg.sv
hdl/dmni_receive.sv
hdl/dmni_send.sv
hdl/dmni_arbiter.sv
hdl/dmni_top.sv
verif/dmni_assertions.sv
verif/dmni_tb.sv

// File: hdl/dmni_arbiter.sv
`timescale 1ns/100ps

module dmni_arbiter #(
    parameter int SLICE_W = 4
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic send_req_i,
    input  logic receive_req_i,
    output logic grant_send_o,
    output logic grant_receive_o
);

    // Low grants the send side, high grants the receive side.
    logic               sel_q;
    logic [SLICE_W-1:0] slice_q;
    logic               holder_req;
    logic               other_req;
    logic               any_req;
    logic               rotate;
    logic               next_sel;

    assign holder_req = sel_q ? receive_req_i : send_req_i;
    assign other_req  = sel_q ? send_req_i : receive_req_i;
    assign any_req    = send_req_i || receive_req_i;

    // Round robin between two sources hands the port over whenever the other side waits.
    assign next_sel = other_req ? !sel_q : sel_q;

    assign rotate = any_req && (slice_q == '0 || !holder_req);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sel_q   <= 1'b0;
            slice_q <= '0;
        end else begin
            if (rotate) begin
                sel_q   <= next_sel;
                slice_q <= '1;
            end else if (slice_q != '0) begin
                slice_q <= slice_q - 1'b1;
            end
        end
    end

    assign grant_send_o    = !sel_q;
    assign grant_receive_o = sel_q;

endmodule

// File: hdl/dmni_pkg.sv
package dmni_pkg;

    // ----------------------------------------------------------
    // Address and size registers
    // ----------------------------------------------------------

    // Byte addresses and buffer sizes share this width.
    localparam int ADDR_W = 32;

    // Consecutive memory words are this many bytes apart.
    localparam logic [ADDR_W-1:0] WORD_BYTES = 32'd4;

    // ----------------------------------------------------------
    // Operation select
    // ----------------------------------------------------------

    localparam int OP_W = 1;

    localparam logic [OP_W-1:0] OP_SEND    = 1'b0;
    localparam logic [OP_W-1:0] OP_RECEIVE = 1'b1;

    // ----------------------------------------------------------
    // Memory port
    // ----------------------------------------------------------

    // Every write stores a whole word.
    localparam logic [3:0] WE_ALL = 4'b1111;

endpackage

// File: hdl/dmni_receive.sv
`timescale 1ns/100ps

module dmni_receive #(
    parameter int FLIT_W = 32
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        noc_rx_i,
    input  logic [FLIT_W-1:0]           noc_data_i,
    output logic                        noc_credit_o,
    input  logic                        start_i,
    input  logic [dmni_pkg::OP_W-1:0]   operation_i,
    input  logic [dmni_pkg::ADDR_W-1:0] address_i,
    input  logic [dmni_pkg::ADDR_W-1:0] size_i,
    input  logic                        grant_i,
    output logic                        active_o,
    output logic                        available_o,
    output logic [FLIT_W-1:0]           flits_available_o,
    output logic                        wr_en_o,
    output logic [dmni_pkg::ADDR_W-1:0] wr_addr_o
);

    localparam logic [3:0] ST_HEADER = 4'b0001;
    localparam logic [3:0] ST_SIZE   = 4'b0010;
    localparam logic [3:0] ST_WAIT   = 4'b0100;
    localparam logic [3:0] ST_DATA   = 4'b1000;

    localparam logic [dmni_pkg::ADDR_W-1:0] SIZE_ONE = 1;
    localparam logic [FLIT_W-1:0]           FLIT_ONE = 1;

    logic [3:0]                  state_q;
    logic [3:0]                  state_d;
    logic [FLIT_W-1:0]           flit_cnt_q;
    logic [dmni_pkg::ADDR_W-1:0] addr_q;
    logic [dmni_pkg::ADDR_W-1:0] size_q;
    logic                        accept;

    // A payload flit moves only while the memory port belongs to this side.
    assign accept = noc_rx_i && grant_i && (state_q == ST_DATA);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_HEADER: begin
                if (noc_rx_i) state_d = ST_SIZE;
            end
            ST_SIZE: begin
                if (noc_rx_i) state_d = ST_WAIT;
            end
            ST_WAIT: begin
                if (start_i && operation_i == dmni_pkg::OP_RECEIVE) state_d = ST_DATA;
            end
            ST_DATA: begin
                // The end of the message takes priority over a full buffer.
                if (accept && flit_cnt_q == FLIT_ONE) begin
                    state_d = ST_HEADER;
                end else if (accept && size_q == SIZE_ONE) begin
                    state_d = ST_WAIT;
                end
            end
            default: state_d = ST_HEADER;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= ST_HEADER;
            flit_cnt_q <= '0;
            addr_q     <= '0;
            size_q     <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_SIZE && noc_rx_i) begin
                flit_cnt_q <= noc_data_i;
            end else if (accept) begin
                flit_cnt_q <= flit_cnt_q - FLIT_ONE;
            end
            if (state_q == ST_WAIT) begin
                addr_q <= address_i;
                size_q <= size_i;
            end else if (accept) begin
                addr_q <= addr_q + dmni_pkg::WORD_BYTES;
                size_q <= size_q - SIZE_ONE;
            end
        end
    end

    // Credit drops in the wait state so the NoC holds the payload back.
    assign noc_credit_o = (state_q == ST_DATA) ? (noc_rx_i && grant_i)
                                               : (state_q != ST_WAIT);

    assign wr_en_o   = accept;
    assign wr_addr_o = addr_q;

    assign active_o          = (state_q == ST_DATA);
    assign available_o       = (state_q == ST_WAIT);
    assign flits_available_o = flit_cnt_q;

endmodule

// File: hdl/dmni_send.sv
`timescale 1ns/100ps

module dmni_send (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        noc_ack_i,
    output logic                        noc_tx_o,
    input  logic                        start_i,
    input  logic [dmni_pkg::OP_W-1:0]   operation_i,
    input  logic [dmni_pkg::ADDR_W-1:0] address_i,
    input  logic [dmni_pkg::ADDR_W-1:0] address_2_i,
    input  logic [dmni_pkg::ADDR_W-1:0] size_i,
    input  logic [dmni_pkg::ADDR_W-1:0] size_2_i,
    input  logic                        grant_i,
    output logic                        active_o,
    output logic [dmni_pkg::ADDR_W-1:0] rd_addr_o
);

    localparam logic [1:0] ST_IDLE = 2'b01;
    localparam logic [1:0] ST_DATA = 2'b10;

    localparam logic [dmni_pkg::ADDR_W-1:0] SIZE_ONE = 1;

    logic [1:0]                  state_q;
    logic [1:0]                  state_d;
    logic [dmni_pkg::ADDR_W-1:0] addr_q;
    logic [dmni_pkg::ADDR_W-1:0] addr_2_q;
    logic [dmni_pkg::ADDR_W-1:0] size_q;
    logic [dmni_pkg::ADDR_W-1:0] size_2_q;
    logic                        fetch;
    logic                        in_first;
    logic                        last_word;

    assign fetch    = noc_ack_i && grant_i && (state_q == ST_DATA);
    assign in_first = (size_q != '0);

    // The word fetched now is the final one of region 1 plus region 2.
    assign last_word = (size_q == SIZE_ONE && size_2_q == '0)
                    || (size_q == '0 && size_2_q == SIZE_ONE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_i && operation_i == dmni_pkg::OP_SEND) state_d = ST_DATA;
            end
            ST_DATA: begin
                if (fetch && last_word) state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // ----------------------------------------------------------
    // Region pointers
    // ----------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= ST_IDLE;
            addr_q   <= '0;
            addr_2_q <= '0;
            size_q   <= '0;
            size_2_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_IDLE) begin
                addr_q   <= address_i;
                addr_2_q <= address_2_i;
                size_q   <= size_i;
                size_2_q <= size_2_i;
            end else if (fetch && in_first) begin
                addr_q <= addr_q + dmni_pkg::WORD_BYTES;
                size_q <= size_q - SIZE_ONE;
            end else if (fetch) begin
                addr_2_q <= addr_2_q + dmni_pkg::WORD_BYTES;
                size_2_q <= size_2_q - SIZE_ONE;
            end
        end
    end

    // Read data returns one cycle after the address, so tx follows a cycle late.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            noc_tx_o <= 1'b0;
        end else begin
            noc_tx_o <= fetch;
        end
    end

    assign rd_addr_o = in_first ? addr_q : addr_2_q;
    assign active_o  = (state_q == ST_DATA);

endmodule

// File: hdl/dmni_top.sv
`timescale 1ns/100ps

module dmni_top #(
    parameter int FLIT_W  = 32,
    parameter int SLICE_W = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    // Hermes input port
    input  logic                        noc_rx_i,
    output logic                        noc_credit_o,
    input  logic [FLIT_W-1:0]           noc_data_i,

    // Hermes output port
    output logic                        noc_tx_o,
    input  logic                        noc_ack_i,
    output logic [FLIT_W-1:0]           noc_data_o,

    // Memory port
    output logic [3:0]                  mem_we_o,
    output logic [dmni_pkg::ADDR_W-1:0] mem_addr_o,
    output logic [FLIT_W-1:0]           mem_data_o,
    input  logic [FLIT_W-1:0]           mem_data_i,

    // Configuration and status
    input  logic                        start_i,
    input  logic [dmni_pkg::OP_W-1:0]   operation_i,
    input  logic [dmni_pkg::ADDR_W-1:0] size_i,
    input  logic [dmni_pkg::ADDR_W-1:0] size_2_i,
    input  logic [dmni_pkg::ADDR_W-1:0] address_i,
    input  logic [dmni_pkg::ADDR_W-1:0] address_2_i,
    output logic                        send_active_o,
    output logic                        receive_active_o,
    output logic                        receive_available_o,
    output logic [FLIT_W-1:0]           receive_flits_available_o
);

    logic                        grant_send;
    logic                        grant_receive;
    logic                        wr_en;
    logic [dmni_pkg::ADDR_W-1:0] wr_addr;
    logic [dmni_pkg::ADDR_W-1:0] rd_addr;

    dmni_receive #(
        .FLIT_W(FLIT_W)
    ) receive_i (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .noc_rx_i          (noc_rx_i),
        .noc_data_i        (noc_data_i),
        .noc_credit_o      (noc_credit_o),
        .start_i           (start_i),
        .operation_i       (operation_i),
        .address_i         (address_i),
        .size_i            (size_i),
        .grant_i           (grant_receive),
        .active_o          (receive_active_o),
        .available_o       (receive_available_o),
        .flits_available_o (receive_flits_available_o),
        .wr_en_o           (wr_en),
        .wr_addr_o         (wr_addr)
    );

    dmni_send send_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .noc_ack_i   (noc_ack_i),
        .noc_tx_o    (noc_tx_o),
        .start_i     (start_i),
        .operation_i (operation_i),
        .address_i   (address_i),
        .address_2_i (address_2_i),
        .size_i      (size_i),
        .size_2_i    (size_2_i),
        .grant_i     (grant_send),
        .active_o    (send_active_o),
        .rd_addr_o   (rd_addr)
    );

    dmni_arbiter #(
        .SLICE_W(SLICE_W)
    ) arbiter_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .send_req_i      (send_active_o),
        .receive_req_i   (receive_active_o),
        .grant_send_o    (grant_send),
        .grant_receive_o (grant_receive)
    );

    // ----------------------------------------------------------
    // Shared memory port
    // ----------------------------------------------------------

    assign mem_addr_o = grant_receive ? wr_addr : rd_addr;
    assign mem_data_o = noc_data_i;
    assign mem_we_o   = wr_en ? dmni_pkg::WE_ALL : '0;

    // Outgoing flits are the read data of the previous cycle.
    assign noc_data_o = mem_data_i;

endmodule

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dmni_tb -f dmni.f -o dmni_sim

./obj_dir/dmni_sim 2>&1 | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// File: verif/dmni_assertions.sv
`timescale 1ns/100ps

module dmni_assertions (
    input logic       clk_i,
    input logic       rst_ni,
    input logic       credit_i,
    input logic       available_i,
    input logic [3:0] mem_we_i,
    input logic       receive_active_i,
    input logic       grant_send_i,
    input logic       grant_receive_i
);

    // ----------------------------------------------------------
    // Receive side
    // ----------------------------------------------------------

    // The NoC is held back while the receive machine waits for a buffer.
    credit_low_in_wait: assert property (
        @(posedge clk_i) disable iff (!rst_ni) available_i |-> !credit_i
    ) else $error("credit is high while the receive machine waits for a buffer");

    // Only an active receive writes memory.
    write_only_when_active: assert property (
        @(posedge clk_i) disable iff (!rst_ni) (mem_we_i != 4'd0) |-> receive_active_i
    ) else $error("memory write while no receive is active");

    // ----------------------------------------------------------
    // Arbiter
    // ----------------------------------------------------------

    grants_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !(grant_send_i && grant_receive_i)
    ) else $error("send and receive both hold the memory port");

endmodule

// File: verif/dmni_tb.sv
`timescale 1ns/100ps

module dmni_tb;

    localparam int FLIT_W      = 32;
    localparam int SLICE_W     = 4;
    localparam int HALF_PERIOD = 50;
    localparam int DRIVE_DELAY = 10;
    localparam int MEM_AW      = 10;
    localparam int NUM_ROWS    = 4;
    localparam logic [31:0] RX_BUF_ADDR = 32'h0000_0c00;

    typedef struct {
        string                     name;
        logic [dmni_pkg::OP_W-1:0] op;
        logic [31:0]               address;
        logic [31:0]               size;
        logic [31:0]               address_2;
        logic [31:0]               size_2;
        logic [31:0]               flits;
    } row_t;

    logic                        clk_i;
    logic                        rst_ni;
    logic                        noc_rx_i;
    logic                        noc_credit_o;
    logic [FLIT_W-1:0]           noc_data_i;
    logic                        noc_tx_o;
    logic                        noc_ack_i;
    logic [FLIT_W-1:0]           noc_data_o;
    logic [3:0]                  mem_we_o;
    logic [dmni_pkg::ADDR_W-1:0] mem_addr_o;
    logic [FLIT_W-1:0]           mem_data_o;
    logic [FLIT_W-1:0]           mem_data_i;
    logic                        start_i;
    logic [dmni_pkg::OP_W-1:0]   operation_i;
    logic [dmni_pkg::ADDR_W-1:0] size_i;
    logic [dmni_pkg::ADDR_W-1:0] size_2_i;
    logic [dmni_pkg::ADDR_W-1:0] address_i;
    logic [dmni_pkg::ADDR_W-1:0] address_2_i;
    logic                        send_active_o;
    logic                        receive_active_o;
    logic                        receive_available_o;
    logic [FLIT_W-1:0]           receive_flits_available_o;

    row_t        rows [NUM_ROWS];
    logic [31:0] mem [2**MEM_AW];
    logic [31:0] ref_mem [2**MEM_AW];
    logic [31:0] sent_q [$];
    logic [31:0] expect_q [$];
    logic [31:0] payload_q [$];
    logic [31:0] lfsr_q;
    string       test_name;

    dmni_top #(
        .FLIT_W  (FLIT_W),
        .SLICE_W (SLICE_W)
    ) dmni_top_i (.*);

    bind dmni_top dmni_assertions assertions_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .credit_i         (noc_credit_o),
        .available_i      (receive_available_o),
        .mem_we_i         (mem_we_o),
        .receive_active_i (receive_active_o),
        .grant_send_i     (grant_send),
        .grant_receive_i  (grant_receive)
    );

    initial begin
        clk_i = 1'b0;
        forever #(HALF_PERIOD) clk_i = ~clk_i;
    end

    // Word memory with synchronous read. The port is sampled at the falling edge.
    initial begin
        logic [3:0]  port_we;
        int          port_idx;
        logic [31:0] port_wdata;
        logic [31:0] read_word;
        mem_data_i = '0;
        forever begin
            @(negedge clk_i);
            port_we    = mem_we_o;
            port_idx   = int'(mem_addr_o[MEM_AW+1:2]);
            port_wdata = mem_data_o;
            @(posedge clk_i);
            read_word = mem[port_idx];
            if (port_we != 4'd0) mem[port_idx] = port_wdata;
            #(DRIVE_DELAY);
            mem_data_i = read_word;
        end
    end

    // The Hermes sink takes one flit on every cycle with tx high.
    always @(negedge clk_i) begin
        if (rst_ni && noc_tx_o) sent_q.push_back(noc_data_o);
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            bits   = {bits[30:0], lfsr_q[0]};
        end
        return bits;
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'(addr[MEM_AW+1:2]);
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            fail_run($sformatf("mismatch %s %s: expected %h actual %h",
                               test_name, what, expected, actual));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #(DRIVE_DELAY);
    endtask

    task automatic drive_flit(input logic [31:0] flit);
        logic taken;
        // About one cycle in four stays idle before a flit.
        while (take_bits(2) == 32'd0) begin
            noc_rx_i = 1'b0;
            next_cycle();
        end
        noc_rx_i   = 1'b1;
        noc_data_i = flit;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge clk_i);
            taken = noc_credit_o;
            next_cycle();
        end
        noc_rx_i = 1'b0;
    endtask

    task automatic drive_message(input logic [31:0] count);
        drive_flit(take_bits(32));
        drive_flit(count);
        foreach (payload_q[i]) drive_flit(payload_q[i]);
    endtask

    task automatic start_op(input logic [dmni_pkg::OP_W-1:0] op,
                            input logic [31:0] addr, input logic [31:0] size,
                            input logic [31:0] addr_2, input logic [31:0] size_2);
        start_i     = 1'b1;
        operation_i = op;
        address_i   = addr;
        size_i      = size;
        address_2_i = addr_2;
        size_2_i    = size_2;
        next_cycle();
        start_i = 1'b0;
    endtask

    task automatic wait_available();
        @(negedge clk_i);
        while (!receive_available_o) @(negedge clk_i);
        next_cycle();
    endtask

    task automatic wait_idle();
        @(negedge clk_i);
        while (send_active_o || receive_active_o) @(negedge clk_i);
        // The last flit leaves one cycle after its fetch.
        next_cycle();
        next_cycle();
    endtask

    task automatic set_row(input int r, input string name,
                           input logic [dmni_pkg::OP_W-1:0] op,
                           input logic [31:0] address, input logic [31:0] size,
                           input logic [31:0] address_2, input logic [31:0] size_2,
                           input logic [31:0] flits);
        rows[r] = '{name, op, address, size, address_2, size_2, flits};
    endtask

    // ----------------------------------------------------------
    // Test rows
    // ----------------------------------------------------------

    // A send row with flits also receives a message into RX_BUF_ADDR meanwhile.
    task automatic load_table();
        set_row(0, "whole_rx", dmni_pkg::OP_RECEIVE, 32'h100, 8, 32'h000, 0, 8);
        set_row(1, "split_rx", dmni_pkg::OP_RECEIVE, 32'h200, 5, 32'h300, 7, 12);
        set_row(2, "two_region_tx", dmni_pkg::OP_SEND, 32'h400, 6, 32'h600, 9, 0);
        set_row(3, "concurrent", dmni_pkg::OP_SEND, 32'h800, 20, 32'ha00, 13, 24);
    endtask

    task automatic run_row(input int r);
        int          sent_base;
        logic [31:0] rx_addr;
        logic [31:0] rx_size;
        test_name = rows[r].name;
        sent_base = sent_q.size();
        expect_q.delete();
        payload_q.delete();
        rx_addr = (rows[r].op == dmni_pkg::OP_RECEIVE) ? rows[r].address : RX_BUF_ADDR;
        rx_size = (rows[r].op == dmni_pkg::OP_RECEIVE) ? rows[r].size : rows[r].flits;
        if (rows[r].op == dmni_pkg::OP_SEND) begin
            for (int i = 0; i < rows[r].size; i++)
                expect_q.push_back(ref_mem[word_index(rows[r].address) + i]);
            for (int i = 0; i < rows[r].size_2; i++)
                expect_q.push_back(ref_mem[word_index(rows[r].address_2) + i]);
        end
        for (int i = 0; i < rows[r].flits; i++) begin
            payload_q.push_back(take_bits(32));
            if (i < rx_size) ref_mem[word_index(rx_addr) + i] = payload_q[i];
            else ref_mem[word_index(rows[r].address_2) + i - rx_size] = payload_q[i];
        end
        fork
            if (rows[r].flits != 0) drive_message(rows[r].flits);
            begin
                if (rows[r].flits != 0) begin
                    wait_available();
                    check_value("flits available", rows[r].flits, receive_flits_available_o);
                    start_op(dmni_pkg::OP_RECEIVE, rx_addr, rx_size, '0, '0);
                end
                if (rows[r].op == dmni_pkg::OP_SEND) begin
                    start_op(dmni_pkg::OP_SEND, rows[r].address, rows[r].size,
                             rows[r].address_2, rows[r].size_2);
                end
                wait_idle();
                if (rx_size < rows[r].flits) begin
                    check_value("available", 1, receive_available_o);
                    check_value("flits pending", rows[r].flits - rx_size,
                                receive_flits_available_o);
                    start_op(dmni_pkg::OP_RECEIVE, rows[r].address_2, rows[r].size_2, '0, '0);
                    wait_idle();
                end
            end
        join
        check_value("flit count", expect_q.size(), sent_q.size() - sent_base);
        foreach (expect_q[i])
            check_value($sformatf("flit %0d", i), expect_q[i], sent_q[sent_base + i]);
        for (int w = 0; w < 2**MEM_AW; w++)
            check_value($sformatf("word %0h", w * 4), ref_mem[w], mem[w]);
        check_value("credit at end", 1, noc_credit_o);
    endtask

    // ----------------------------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------------------------

    initial begin
        lfsr_q      = 32'ha6a7_7af6;
        rst_ni      = 1'b0;
        noc_rx_i    = 1'b0;
        noc_data_i  = '0;
        noc_ack_i   = 1'b1;
        start_i     = 1'b0;
        operation_i = dmni_pkg::OP_SEND;
        size_i      = '0;
        size_2_i    = '0;
        address_i   = '0;
        address_2_i = '0;
        test_name   = "reset";
        load_table();
        for (int w = 0; w < 2**MEM_AW; w++) begin
            mem[w]     = take_bits(32);
            ref_mem[w] = mem[w];
        end
        repeat (4) @(posedge clk_i);
        #(DRIVE_DELAY);
        rst_ni = 1'b1;
        check_value("credit", 1, noc_credit_o);
        check_value("tx", 0, noc_tx_o);
        check_value("mem_we", 0, mem_we_o);
        check_value("available", 0, receive_available_o);
        check_value("send active", 0, send_active_o);
        check_value("receive active", 0, receive_active_o);
        for (int r = 0; r < NUM_ROWS; r++) run_row(r);
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        int cycles;
        #1;
        cycles = 500;
        for (int r = 0; r < NUM_ROWS; r++)
            cycles += 40 * int'(rows[r].size + rows[r].size_2 + rows[r].flits);
        repeat (cycles) @(posedge clk_i);
        fail_run("timeout: the tests did not finish in the expected number of cycles");
    end

endmodule
